/* src/rs232_pkg.sv */
`default_nettype none

package rs232_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // register map
  localparam logic [addr_w-1:0] tx_addr = 32'hf000_0000; // write: send low byte
  localparam logic [addr_w-1:0] rx_addr = 32'hf000_0001; // read: last received byte

  // serial timing
  // kept small so a frame only takes 160 clocks in simulation
  localparam int clks_per_bit = 16;

  // bit-timing counter runs 0 .. clks_per_bit-1
  localparam int bit_cnt_w = $clog2(clks_per_bit);

endpackage

`default_nettype wire

/* src/uart_tx.sv */
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,  // one-cycle pulse, only while idle
  input  logic [7:0] tx_byte,
  output logic       txd,       // registered line output
  output logic       tx_busy
);
  import rs232_pkg::*;

  logic [bit_cnt_w-1:0] bit_cnt;  // clocks within current bit
  logic [3:0]           bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [8:0]           shreg;    // data bits then stop bit, lsb goes out first
  logic                 bit_end;  // last clock of current bit
  logic                 last_bit; // stop bit on the line

  assign bit_end  = (bit_cnt == bit_cnt_w'(clks_per_bit - 1));
  assign last_bit = (bit_idx == 4'd9);

  // control path
  always_ff @(posedge clk) begin
    if (rst) begin
      txd     <= 1'b1;  // line idles high
      tx_busy <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else if (!tx_busy) begin
      bit_cnt <= '0;
      bit_idx <= '0;
      if (tx_start) begin
        tx_busy <= 1'b1;
        txd     <= 1'b0; // start bit goes out next cycle
      end
    end else if (bit_end) begin
      bit_cnt <= '0;
      if (last_bit) begin
        // stop bit done, back to idle
        tx_busy <= 1'b0;
        txd     <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 4'd1;
        txd     <= shreg[0];
      end
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // payload shift register
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      shreg <= {1'b1, tx_byte}; // stop bit sits above the data
    end else if (tx_busy && bit_end && !last_bit) begin
      shreg <= {1'b1, shreg[8:1]}; // shift toward lsb, fill with ones
    end
  end

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`default_nettype none

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,       // asynchronous serial input
  output logic       rx_valid,  // one-cycle pulse on a good frame
  output logic [7:0] rx_byte
);
  import rs232_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t            state;
  logic                 rxd_meta;   // first synchronizer stage
  logic                 rxd_sync;   // second stage, safe to use
  logic                 rxd_prev;   // for edge detect
  logic                 fall_edge;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [2:0]           bit_idx;    // data bit number
  logic                 half_end;   // middle of start bit reached
  logic                 bit_end;    // one full bit time elapsed

  assign fall_edge = rxd_prev && !rxd_sync;
  assign half_end  = (bit_cnt == bit_cnt_w'(clks_per_bit / 2 - 1));
  assign bit_end   = (bit_cnt == bit_cnt_w'(clks_per_bit - 1));

  // two-flop synchronizer plus delayed copy
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // frame FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= rx_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0; // default, pulse only
      case (state)
        rx_idle: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          if (fall_edge) begin
            state <= rx_start;
          end
        end

        rx_start: begin
          if (half_end) begin
            bit_cnt <= '0;
            // glitch if the line went back high
            state   <= rxd_sync ? rx_idle : rx_data;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        rx_data: begin
          if (bit_end) begin
            bit_cnt <= '0; // now at middle of a data bit
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        rx_stop: begin
          if (bit_end) begin
            bit_cnt  <= '0;
            rx_valid <= rxd_sync; // bad stop bit drops the frame
            state    <= rx_idle;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        default: state <= rx_idle;
      endcase
    end
  end

  // data bits arrive lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == rx_data && bit_end) begin
      rx_byte <= {rxd_sync, rx_byte[7:1]};
    end
  end

endmodule

`default_nettype wire

/* src/rs232_port.sv */
`default_nettype none

module rs232_port (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rs232_pkg::addr_w-1:0] addr_in,
  input  logic [rs232_pkg::data_w-1:0] data_in,
  input  logic                         read_q,
  input  logic                         write_q,
  output logic [rs232_pkg::addr_w-1:0] addr_out,
  output logic [rs232_pkg::data_w-1:0] data_out,
  output logic                         read_dn,
  output logic                         write_dn,
  output logic                         tx_start,
  output logic [7:0]                   tx_byte,
  input  logic                         tx_busy,
  input  logic                         rx_valid,
  input  logic [7:0]                   rx_byte
);
  import rs232_pkg::*;

  typedef enum logic [1:0] {
    wait_cmd,
    send_byte,
    receive_byte
  } port_state_t;

  port_state_t       state;
  logic [addr_w-1:0] addr_r;   // address of current access
  logic [data_w-1:0] data_r;   // write data, echoed on write_dn
  logic [7:0]        rx_buf;   // single receive buffer
  logic              rx_full;
  logic              wr_hit;
  logic              rd_hit;

  // address decode, write wins if both strobes are up
  assign wr_hit = write_q && (addr_in == tx_addr);
  assign rd_hit = read_q && (addr_in == rx_addr);

  // done pulses come straight from state, same cycle as the event
  assign write_dn = (state == send_byte) && !tx_busy;
  assign tx_start = write_dn; // transmitter launched with the done pulse
  assign read_dn  = (state == receive_byte) && rx_full;

  // echo bus only during a done pulse
  always_comb begin
    addr_out = '0;
    data_out = '0;
    if (write_dn) begin
      addr_out = addr_r;
      data_out = data_r;
    end else if (read_dn) begin
      addr_out = addr_r;
      data_out = {{(data_w - 8){1'b0}}, rx_buf}; // zero-extend
    end
  end

  // access FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wait_cmd;
    end else begin
      case (state)
        wait_cmd: begin
          if (wr_hit) begin
            state <= send_byte;
          end else if (rd_hit) begin
            state <= receive_byte;
          end
        end

        send_byte: begin
          if (write_dn) begin
            state <= wait_cmd;
          end
        end

        receive_byte: begin
          if (read_dn) begin
            state <= wait_cmd;
          end
        end

        default: state <= wait_cmd;
      endcase
    end
  end

  // latch request in idle
  always_ff @(posedge clk) begin
    if (state == wait_cmd && (wr_hit || rd_hit)) begin
      addr_r  <= addr_in;
      data_r  <= data_in;
      tx_byte <= data_in[7:0]; // only low byte is sent
    end
  end

  // receive buffer fills in any state, newer byte overwrites
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_full <= 1'b0;
    end else if (rx_valid) begin
      rx_full <= 1'b1; // new byte beats a read in the same cycle
    end else if (read_dn) begin
      rx_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rx_buf <= rx_byte;
    end
  end

endmodule

`default_nettype wire

/* src/rs232_subsystem.sv */
`default_nettype none

module rs232_subsystem (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rs232_pkg::addr_w-1:0] addr_in,
  input  logic [rs232_pkg::data_w-1:0] data_in,
  input  logic                         read_q,
  input  logic                         write_q,
  output logic [rs232_pkg::addr_w-1:0] addr_out,
  output logic [rs232_pkg::data_w-1:0] data_out,
  output logic                         read_dn,
  output logic                         write_dn,
  input  logic                         rxd,
  output logic                         txd
);

  // port to transmitter
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;

  // receiver to port
  logic       rx_valid;
  logic [7:0] rx_byte;

  rs232_port rs232_port_i (
    .clk      (clk),
    .rst      (rst),
    .addr_in  (addr_in),
    .data_in  (data_in),
    .read_q   (read_q),
    .write_q  (write_q),
    .addr_out (addr_out),
    .data_out (data_out),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .txd      (txd),
    .tx_busy  (tx_busy)
  );

  uart_rx uart_rx_i (
    .clk      (clk),
    .rst      (rst),
    .rxd      (rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

endmodule

`default_nettype wire

/* testbench/tb_rs232_subsystem.sv */
`default_nettype none

module tb_rs232_subsystem;
  import rs232_pkg::*;

  localparam int frame_clks   = 10 * clks_per_bit; // start + 8 data + stop
  localparam int done_timeout = 4 * frame_clks;    // longest legal wait for a done pulse

  logic              clk;
  logic              rst;
  logic [addr_w-1:0] addr_in;
  logic [data_w-1:0] data_in;
  logic              read_q;
  logic              write_q;
  logic [addr_w-1:0] addr_out;
  logic [data_w-1:0] data_out;
  logic              read_dn;
  logic              write_dn;
  logic              rxd;
  logic              txd;

  rs232_subsystem rs232_subsystem_i (
    .clk      (clk),
    .rst      (rst),
    .addr_in  (addr_in),
    .data_in  (data_in),
    .read_q   (read_q),
    .write_q  (write_q),
    .addr_out (addr_out),
    .data_out (data_out),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .rxd      (rxd),
    .txd      (txd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // period 40
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout: %s", what);
    $display("TEST FAILED");
    $fatal(1, "wait timed out");
  endtask

  // serial line model, one bit on rxd for a full bit time
  task automatic drive_bit(input logic v);
    @(negedge clk);
    rxd = v;
    repeat (clks_per_bit - 1) @(negedge clk);
  endtask

  // 8N1 frame into rxd, stop_ok low gives a framing error
  task automatic send_frame(input logic [7:0] b, input logic stop_ok);
    int i;
    drive_bit(1'b0); // start
    for (i = 0; i < 8; i++) begin
      drive_bit(b[i]); // lsb first
    end
    drive_bit(stop_ok);
    drive_bit(1'b1); // idle gap, line back high
  endtask

  // decode one frame from txd at mid-bit
  task automatic receive_tx_frame(output logic [7:0] b);
    int n;
    int i;
    n = 0;
    while (txd !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > done_timeout) fail_timeout("no start bit seen on txd");
    end
    repeat (clks_per_bit / 2) @(negedge clk); // middle of start bit
    check("txd start bit", 32'd0, {31'd0, txd});
    for (i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = txd;
    end
    repeat (clks_per_bit) @(negedge clk);
    check("txd stop bit", 32'd1, {31'd0, txd});
  endtask

  // write access, strobe held until write_dn
  task automatic bus_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           output logic [addr_w-1:0] a_out,
                           output logic [data_w-1:0] d_out);
    int n;
    @(negedge clk);
    addr_in = addr;
    data_in = data;
    write_q = 1'b1;
    n = 0;
    @(negedge clk);
    while (!write_dn) begin
      n++;
      if (n > done_timeout) fail_timeout("write_dn never arrived");
      @(negedge clk);
    end
    a_out   = addr_out; // echo only valid during the pulse
    d_out   = data_out;
    write_q = 1'b0;
    addr_in = '0;
    data_in = '0;
  endtask

  // read access, strobe held until read_dn
  task automatic bus_read(input logic [addr_w-1:0] addr,
                          output logic [addr_w-1:0] a_out,
                          output logic [data_w-1:0] d_out);
    int n;
    @(negedge clk);
    addr_in = addr;
    read_q  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!read_dn) begin
      n++;
      if (n > done_timeout) fail_timeout("read_dn never arrived");
      @(negedge clk);
    end
    a_out   = addr_out;
    d_out   = data_out;
    read_q  = 1'b0;
    addr_in = '0;
  endtask

  // strobe on an unmapped address, nothing may answer
  task automatic hold_unmapped(input logic is_write, input logic [addr_w-1:0] addr,
                               input logic [data_w-1:0] data);
    @(negedge clk);
    addr_in = addr;
    data_in = data;
    write_q = is_write;
    read_q  = !is_write;
    repeat (2 * frame_clks) begin
      @(negedge clk);
      check("decode write_dn", 32'd0, {31'd0, write_dn});
      check("decode read_dn", 32'd0, {31'd0, read_dn});
      check("decode txd idle", 32'd1, {31'd0, txd});
      check("decode addr_out", 32'd0, addr_out);
    end
    write_q = 1'b0; // drop the strobe again
    read_q  = 1'b0;
    addr_in = '0;
    data_in = '0;
  endtask

  task automatic test_idle();
    repeat (20) begin
      @(negedge clk);
      check("idle read_dn", 32'd0, {31'd0, read_dn});
      check("idle write_dn", 32'd0, {31'd0, write_dn});
      check("idle txd", 32'd1, {31'd0, txd});
      check("idle addr_out", 32'd0, addr_out);
      check("idle data_out", 32'd0, data_out);
    end
  endtask

  task automatic test_transmit();
    logic [data_w-1:0] wdata;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    logic [7:0]        b;
    logic [data_w-1:0] wq [4];
    logic [7:0]        rq [4];
    int                i;
    wdata = $urandom;
    bus_write(tx_addr, wdata, a, d);
    check("transmit addr_out", tx_addr, a);
    check("transmit data_out", wdata, d);
    receive_tx_frame(b);
    check("transmit byte", {24'd0, wdata[7:0]}, {24'd0, b});
    for (i = 0; i < 4; i++) begin
      wq[i] = $urandom;
    end
    // writer and line monitor run side by side
    fork
      begin
        logic [addr_w-1:0] wa;
        logic [data_w-1:0] wd;
        for (int k = 0; k < 4; k++) begin
          bus_write(tx_addr, wq[k], wa, wd);
          check("back-to-back data_out", wq[k], wd);
        end
      end
      begin
        for (int k = 0; k < 4; k++) begin
          receive_tx_frame(rq[k]);
        end
      end
    join
    for (i = 0; i < 4; i++) begin
      check("back-to-back byte order", {24'd0, wq[i][7:0]}, {24'd0, rq[i]});
    end
  endtask

  task automatic test_receive();
    logic [7:0]        b;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    b = 8'($urandom);
    send_frame(b, 1'b1);
    bus_read(rx_addr, a, d);
    check("receive addr_out", rx_addr, a);
    check("receive data_out", {24'd0, b}, d); // zero-extended
    // read waits for a frame still to come
    b = 8'($urandom);
    fork
      bus_read(rx_addr, a, d);
      begin
        repeat (10) @(negedge clk);
        send_frame(b, 1'b1);
      end
    join
    check("early read data_out", {24'd0, b}, d);
  endtask

  task automatic test_buffer();
    logic [7:0]        b1;
    logic [7:0]        b2;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    b1 = 8'($urandom);
    b2 = ~b1; // keep the two apart
    send_frame(b1, 1'b1);
    send_frame(b2, 1'b1);
    bus_read(rx_addr, a, d);
    check("overwrite keeps newer byte", {24'd0, b2}, d);
    // framing error, frame must vanish
    b1 = 8'($urandom);
    b2 = ~b1;
    send_frame(b1, 1'b0);
    // read starts on an empty buffer, only the good frame may end it
    fork
      bus_read(rx_addr, a, d);
      send_frame(b2, 1'b1);
    join
    check("bad stop bit dropped", {24'd0, b2}, d);
    // buffer now empty, read must stall a full frame
    b1 = 8'($urandom);
    fork
      bus_read(rx_addr, a, d);
      begin
        repeat (frame_clks) begin
          @(negedge clk);
          check("empty buffer read_dn", 32'd0, {31'd0, read_dn});
        end
        send_frame(b1, 1'b1);
      end
    join
    check("read after empty buffer", {24'd0, b1}, d);
  endtask

  task automatic test_decode();
    logic [data_w-1:0] wdata;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    logic [7:0]        b;
    hold_unmapped(1'b1, 32'hf000_0004, $urandom);
    hold_unmapped(1'b1, rx_addr, $urandom); // write to the read register
    hold_unmapped(1'b0, 32'hf000_0010, '0);
    wdata = $urandom;
    bus_write(tx_addr, wdata, a, d);
    check("write after decode addr_out", tx_addr, a);
    check("write after decode data_out", wdata, d);
    receive_tx_frame(b);
    check("write after decode byte", {24'd0, wdata[7:0]}, {24'd0, b});
  endtask

  initial begin
    void'($urandom(32'h292e3954)); // seeds the generator for the run
    rst     = 1'b1;
    addr_in = '0;
    data_in = '0;
    read_q  = 1'b0;
    write_q = 1'b0;
    rxd     = 1'b1; // line idle
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_idle();
    test_transmit();
    test_receive();
    test_buffer();
    test_decode();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
src/rs232_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/rs232_port.sv
src/rs232_subsystem.sv
testbench/tb_rs232_subsystem.sv

/* Makefile */
SIM  := obj_dir/Vtb_rs232_subsystem
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f project.f \
	  --top-module tb_rs232_subsystem -Mdir obj_dir -o Vtb_rs232_subsystem

# exit status of the binary is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
